//--- hw/raycast_pkg.sv
package raycast_pkg;

  // VGA 640x480 timing, one pixel per clk
  localparam int H_VIEW       = 640;  // Visible pixels per line
  localparam int H_TOTAL      = 800;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;  // First pixel after hsync
  localparam int V_VIEW       = 480;  // Visible lines per frame
  localparam int V_TOTAL      = 525;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 492;  // First line after vsync
  localparam int HALF_VIEW    = H_VIEW / 2;  // Wall centre, also floor/sky split

  // Quad-output fast read from the texture flash
  localparam logic [7:0] TSPI_CMD = 8'h6B;
  localparam int TSPI_CMD_LEN      = 8;   // Command bits on io0
  localparam int TSPI_ADDR_LEN     = 24;  // Address bits on io0
  localparam int TSPI_DUMMY_LEN    = 8;   // Turnaround clocks
  localparam int TSPI_PREAMBLE_LEN = TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN;
  localparam int TEXEL_COUNT       = 64;  // Texels in one wall slice
  localparam int TSPI_READ_LEN     = TEXEL_COUNT * 2;  // Two nibbles per texel

  // Preamble ends exactly as the visible part of the line ends
  localparam int FETCH_START = H_VIEW - TSPI_PREAMBLE_LEN;

  // Texture step is unsigned 6.6 fixed point
  localparam int TEXV_FRAC_BITS = 6;

  typedef logic [9:0]  pos_t;        // hpos or vpos
  typedef logic [5:0]  rgb_t;        // {b1,b0,g1,g0,r1,r0}
  typedef logic [5:0]  texel_idx_t;  // Texel within a slice
  typedef logic [23:0] tex_addr_t;   // Flash byte address
  typedef logic [1:0]  wall_id_t;
  typedef logic [8:0]  wall_size_t;  // Half-width of the wall slice
  typedef logic [11:0] tex_step_t;   // Texture v per pixel

  // Flash fetch sequence, one state per part of the transaction
  typedef enum logic [2:0] {
    FETCH_IDLE,   // CS high
    FETCH_CMD,    // 8 command bits out
    FETCH_ADDR,   // 24 address bits out
    FETCH_DUMMY,  // io0 turned around
    FETCH_READ    // 128 nibbles in
  } fetch_state_t;

endpackage

//--- hw/vga_timing.sv
module vga_timing (
  input  logic              clk,
  input  logic              reset,
  output raycast_pkg::pos_t o_hpos,
  output raycast_pkg::pos_t o_vpos,
  output logic              o_hsync,
  output logic              o_vsync,
  output logic              o_hblank,
  output logic              o_vblank,
  output logic              o_hmax,
  output logic              o_visible
);
  import raycast_pkg::*;

  pos_t h_next;
  pos_t v_next;
  logic h_end;
  logic v_end;

  // Next counter values; sync and blank flags are decoded from these
  // so that the registered flags line up with the registered counters
  always_comb begin
    h_end  = (o_hpos == pos_t'(H_TOTAL - 1));
    v_end  = (o_vpos == pos_t'(V_TOTAL - 1));
    h_next = h_end ? '0 : o_hpos + 1'b1;
    v_next = o_vpos;
    if (h_end) begin
      v_next = v_end ? '0 : o_vpos + 1'b1;  // Frame wrap
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_hpos   <= '0;
      o_vpos   <= '0;
      o_hsync  <= 1'b0;
      o_vsync  <= 1'b0;
      o_hblank <= 1'b0;
      o_vblank <= 1'b0;
    end else begin
      o_hpos   <= h_next;
      o_vpos   <= v_next;
      o_hsync  <= (h_next >= pos_t'(H_SYNC_START)) && (h_next < pos_t'(H_SYNC_END));
      o_vsync  <= (v_next >= pos_t'(V_SYNC_START)) && (v_next < pos_t'(V_SYNC_END));
      o_hblank <= (h_next >= pos_t'(H_VIEW));
      o_vblank <= (v_next >= pos_t'(V_VIEW));
    end
  end

  assign o_hmax    = h_end;  // Line-end strobe
  assign o_visible = !o_hblank && !o_vblank;

endmodule

//--- hw/texture_fetch_ctrl.sv
module texture_fetch_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  raycast_pkg::pos_t       i_hpos,
  input  logic                    i_hmax,
  input  logic                    i_req,
  input  raycast_pkg::wall_id_t   i_wall_id,
  input  logic                    i_side,
  input  raycast_pkg::texel_idx_t i_texu,
  input  raycast_pkg::wall_size_t i_wall_size,
  input  raycast_pkg::tex_step_t  i_tex_step,
  input  raycast_pkg::rgb_t       i_sky_rgb,
  input  raycast_pkg::rgb_t       i_floor_rgb,
  output logic                    o_ack,
  output logic                    o_tex_csb,
  output logic                    o_tex_oeb0,
  output logic                    o_ser_load,
  output raycast_pkg::tex_addr_t  o_ser_addr,
  output logic                    o_ser_shift,
  output logic                    o_capture,
  output logic                    o_odd_nibble,
  output raycast_pkg::wall_size_t o_wall_size,
  output raycast_pkg::tex_step_t  o_tex_step,
  output raycast_pkg::rgb_t       o_sky_rgb,
  output raycast_pkg::rgb_t       o_floor_rgb
);
  import raycast_pkg::*;

  wall_id_t     pend_wall_id;  // Latest descriptor from the host
  logic         pend_side;
  texel_idx_t   pend_texu;
  wall_size_t   pend_size;
  tex_step_t    pend_step;
  rgb_t         pend_sky;
  rgb_t         pend_floor;
  wall_size_t   act_size;      // Display fields of the slice being fetched
  tex_step_t    act_step;
  rgb_t         act_sky;
  rgb_t         act_floor;
  fetch_state_t state;
  fetch_state_t state_next;
  logic [$clog2(TSPI_READ_LEN)-1:0] phase;  // Cycle within the current state
  logic         phase_last;
  logic         fetch_go;

  // Strobe on the cycle before FETCH_START, so load and staging land as hpos reaches it
  assign fetch_go = (i_hpos == pos_t'(FETCH_START - 1));

  // Four-phase req/ack; a new descriptor simply replaces the pending one
  always_ff @(posedge clk) begin
    if (reset) begin
      o_ack        <= 1'b0;
      pend_wall_id <= '0;
      pend_side    <= 1'b0;
      pend_texu    <= '0;
      pend_size    <= '0;
      pend_step    <= '0;
      pend_sky     <= '0;
      pend_floor   <= '0;
    end else if (i_req && !o_ack) begin
      o_ack        <= 1'b1;
      pend_wall_id <= i_wall_id;
      pend_side    <= i_side;
      pend_texu    <= i_texu;
      pend_size    <= i_wall_size;
      pend_step    <= i_tex_step;
      pend_sky     <= i_sky_rgb;
      pend_floor   <= i_floor_rgb;
    end else if (!i_req && o_ack) begin
      o_ack <= 1'b0;  // Host released req
    end
  end

  // Pending -> active at fetch start, active -> display at line end
  always_ff @(posedge clk) begin
    if (reset) begin
      act_size    <= '0;
      act_step    <= '0;
      act_sky     <= '0;
      act_floor   <= '0;
      o_wall_size <= '0;
      o_tex_step  <= '0;
      o_sky_rgb   <= '0;
      o_floor_rgb <= '0;
    end else begin
      if (fetch_go) begin
        act_size  <= pend_size;
        act_step  <= pend_step;
        act_sky   <= pend_sky;
        act_floor <= pend_floor;
      end
      if (i_hmax) begin  // Texture just fetched is drawn on the next line
        o_wall_size <= act_size;
        o_tex_step  <= act_step;
        o_sky_rgb   <= act_sky;
        o_floor_rgb <= act_floor;
      end
    end
  end

  always_comb begin
    state_next = state;
    phase_last = 1'b0;
    unique case (state)
      FETCH_IDLE:  phase_last = fetch_go;
      FETCH_CMD:   phase_last = (phase == TSPI_CMD_LEN - 1);
      FETCH_ADDR:  phase_last = (phase == TSPI_ADDR_LEN - 1);
      FETCH_DUMMY: phase_last = (phase == TSPI_DUMMY_LEN - 1);
      FETCH_READ:  phase_last = (phase == TSPI_READ_LEN - 1);
      default:     phase_last = 1'b1;
    endcase
    if (phase_last) begin
      state_next = (state == FETCH_READ) ? FETCH_IDLE : fetch_state_t'(state + 1'b1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH_IDLE;
      phase <= '0;
    end else begin
      state <= state_next;
      phase <= (phase_last || state == FETCH_IDLE) ? '0 : phase + 1'b1;
    end
  end

  assign o_tex_csb    = (state == FETCH_IDLE);  // Active low
  assign o_tex_oeb0   = (state == FETCH_DUMMY) || (state == FETCH_READ);  // io0 as input
  assign o_ser_load   = fetch_go;
  assign o_ser_addr   = tex_addr_t'({pend_wall_id, pend_side, pend_texu, texel_idx_t'(0)});
  assign o_ser_shift  = (state == FETCH_CMD) || (state == FETCH_ADDR);
  assign o_capture    = (state == FETCH_READ);
  assign o_odd_nibble = phase[0];  // Even nibble low planes, odd nibble high planes

endmodule

//--- hw/qspi_serializer.sv
module qspi_serializer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_load,
  input  raycast_pkg::tex_addr_t i_addr,
  input  logic                   i_shift,
  output logic                   o_out0
);
  import raycast_pkg::*;

  // Command then address, MSB goes out first
  logic [TSPI_CMD_LEN+TSPI_ADDR_LEN-1:0] shreg;

  always_ff @(posedge clk) begin
    if (reset) begin
      shreg <= '0;
    end else if (i_load) begin
      shreg <= {TSPI_CMD, i_addr};
    end else if (i_shift) begin
      shreg <= {shreg[TSPI_CMD_LEN+TSPI_ADDR_LEN-2:0], 1'b0};  // Next bit to the top
    end
  end

  // Flash samples io0 on the rising sclk, mid-cycle, so the bit is settled by then
  assign o_out0 = i_shift ? shreg[TSPI_CMD_LEN+TSPI_ADDR_LEN-1] : 1'b0;

endmodule

//--- hw/texel_buffer.sv
module texel_buffer (
  input  logic                    clk,
  input  logic                    i_capture,
  input  logic                    i_odd_nibble,
  input  logic [3:0]              i_tex_in,
  input  raycast_pkg::texel_idx_t i_texel,
  output raycast_pkg::rgb_t       o_texel_rgb
);
  import raycast_pkg::*;

  // Colour planes indexed 0=r, 1=g, 2=b; bit j of a plane belongs to texel j
  logic [TEXEL_COUNT-1:0] plane_lo [3];  // Colour LSBs, from even nibbles
  logic [TEXEL_COUNT-1:0] plane_hi [3];  // Colour MSBs, from odd nibbles

  // Shift in from the top, so the first texel of the read ends up at bit 0.
  // io3 carries nothing we use
  always_ff @(posedge clk) begin
    if (i_capture) begin
      for (int c = 0; c < 3; c++) begin
        if (i_odd_nibble) begin
          plane_hi[c] <= {i_tex_in[c], plane_hi[c][TEXEL_COUNT-1:1]};
        end else begin
          plane_lo[c] <= {i_tex_in[c], plane_lo[c][TEXEL_COUNT-1:1]};
        end
      end
    end
  end

  // Reassemble one texel as b1 b0 g1 g0 r1 r0
  assign o_texel_rgb = {
    plane_hi[2][i_texel], plane_lo[2][i_texel],  // Blue
    plane_hi[1][i_texel], plane_lo[1][i_texel],  // Green
    plane_hi[0][i_texel], plane_lo[0][i_texel]   // Red
  };

endmodule

//--- hw/wall_column_render.sv
module wall_column_render (
  input  logic                    clk,
  input  logic                    reset,
  input  raycast_pkg::pos_t       i_hpos,
  input  logic                    i_visible,
  input  logic                    i_hmax,
  input  raycast_pkg::wall_size_t i_wall_size,
  input  raycast_pkg::tex_step_t  i_tex_step,
  input  raycast_pkg::rgb_t       i_sky_rgb,
  input  raycast_pkg::rgb_t       i_floor_rgb,
  input  raycast_pkg::rgb_t       i_texel_rgb,
  output raycast_pkg::texel_idx_t o_texel,
  output raycast_pkg::rgb_t       o_rgb
);
  import raycast_pkg::*;

  logic [10:0] hpos_plus_size;  // One bit wider, span edges can pass 0 or 800
  logic [10:0] span_end;
  logic        wall_on;
  tex_step_t   tex_v;           // Texture v accumulator, same 6.6 format as the step

  // Centred span, HALF_VIEW - size <= hpos < HALF_VIEW + size
  always_comb begin
    hpos_plus_size = 11'(i_hpos) + 11'(i_wall_size);
    span_end       = 11'(HALF_VIEW) + 11'(i_wall_size);
    wall_on        = (hpos_plus_size >= 11'(HALF_VIEW)) && (11'(i_hpos) < span_end);
  end

  // Restart v at each line end, step once per wall pixel.
  // Wraps modulo 64 texels by its width
  always_ff @(posedge clk) begin
    if (reset) begin
      tex_v <= '0;
    end else if (i_hmax) begin
      tex_v <= '0;
    end else if (wall_on) begin
      tex_v <= tex_v + i_tex_step;
    end
  end

  // Integer part, taken before this pixel's add
  assign o_texel = tex_v[TEXV_FRAC_BITS +: $bits(texel_idx_t)];

  // Pixel mux: black in blanking, wall texel, else floor on the left half and sky right
  always_comb begin
    if (!i_visible) begin
      o_rgb = '0;
    end else if (wall_on) begin
      o_rgb = i_texel_rgb;
    end else if (i_hpos < pos_t'(HALF_VIEW)) begin
      o_rgb = i_floor_rgb;
    end else begin
      o_rgb = i_sky_rgb;
    end
  end

endmodule

//--- hw/raycast_top.sv
module raycast_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_req,        // Column descriptor handshake
  input  raycast_pkg::wall_id_t   i_wall_id,
  input  logic                    i_side,
  input  raycast_pkg::texel_idx_t i_texu,
  input  raycast_pkg::wall_size_t i_wall_size,
  input  raycast_pkg::tex_step_t  i_tex_step,
  input  raycast_pkg::rgb_t       i_sky_rgb,
  input  raycast_pkg::rgb_t       i_floor_rgb,
  input  logic [3:0]              i_tex_in,     // Flash io[3:0]
  output logic                    o_ack,
  output logic                    o_hsync_n,
  output logic                    o_vsync_n,
  output logic                    o_hblank,
  output logic                    o_vblank,
  output raycast_pkg::pos_t       o_hpos,
  output raycast_pkg::pos_t       o_vpos,
  output raycast_pkg::rgb_t       o_rgb,
  output logic                    o_tex_csb,
  output logic                    o_tex_sclk,
  output logic                    o_tex_out0,
  output logic                    o_tex_oeb0    // 1 when io0 is an input
);
  import raycast_pkg::*;

  logic       hsync;
  logic       vsync;
  logic       hmax;
  logic       visible;
  logic       ser_load;
  tex_addr_t  ser_addr;
  logic       ser_shift;
  logic       capture;
  logic       odd_nibble;
  wall_size_t wall_size;    // Display fields for the current line
  tex_step_t  tex_step;
  rgb_t       sky_rgb;
  rgb_t       floor_rgb;
  texel_idx_t texel;
  rgb_t       texel_rgb;

  assign o_hsync_n  = ~hsync;  // VGA syncs are active low
  assign o_vsync_n  = ~vsync;
  assign o_tex_sclk = ~clk;    // Full-rate SPI clock, io0 launched on clk rise

  vga_timing i_vga_timing (
    .clk       (clk),
    .reset     (reset),
    .o_hpos    (o_hpos),
    .o_vpos    (o_vpos),
    .o_hsync   (hsync),
    .o_vsync   (vsync),
    .o_hblank  (o_hblank),
    .o_vblank  (o_vblank),
    .o_hmax    (hmax),
    .o_visible (visible)
  );

  texture_fetch_ctrl i_fetch_ctrl (
    .clk          (clk),
    .reset        (reset),
    .i_hpos       (o_hpos),
    .i_hmax       (hmax),
    .i_req        (i_req),
    .i_wall_id    (i_wall_id),
    .i_side       (i_side),
    .i_texu       (i_texu),
    .i_wall_size  (i_wall_size),
    .i_tex_step   (i_tex_step),
    .i_sky_rgb    (i_sky_rgb),
    .i_floor_rgb  (i_floor_rgb),
    .o_ack        (o_ack),
    .o_tex_csb    (o_tex_csb),
    .o_tex_oeb0   (o_tex_oeb0),
    .o_ser_load   (ser_load),
    .o_ser_addr   (ser_addr),
    .o_ser_shift  (ser_shift),
    .o_capture    (capture),
    .o_odd_nibble (odd_nibble),
    .o_wall_size  (wall_size),
    .o_tex_step   (tex_step),
    .o_sky_rgb    (sky_rgb),
    .o_floor_rgb  (floor_rgb)
  );

  qspi_serializer i_serializer (
    .clk     (clk),
    .reset   (reset),
    .i_load  (ser_load),
    .i_addr  (ser_addr),
    .i_shift (ser_shift),
    .o_out0  (o_tex_out0)
  );

  texel_buffer i_texel_buffer (
    .clk          (clk),
    .i_capture    (capture),
    .i_odd_nibble (odd_nibble),
    .i_tex_in     (i_tex_in),
    .i_texel      (texel),
    .o_texel_rgb  (texel_rgb)
  );

  wall_column_render i_render (
    .clk         (clk),
    .reset       (reset),
    .i_hpos      (o_hpos),
    .i_visible   (visible),
    .i_hmax      (hmax),
    .i_wall_size (wall_size),
    .i_tex_step  (tex_step),
    .i_sky_rgb   (sky_rgb),
    .i_floor_rgb (floor_rgb),
    .i_texel_rgb (texel_rgb),
    .o_texel     (texel),
    .o_rgb       (o_rgb)
  );

endmodule

//--- tb/raycast_assertions.sv
module raycast_assertions (
  input logic clk,
  input logic reset,
  input logic i_req,
  input logic i_ack,
  input logic i_tex_csb,
  input logic i_tex_oeb0,
  input logic i_tex_out0
);
  timeunit 1ns;
  timeprecision 1ps;

  int error_count = 0;  // Assertion failures so far

  // Ack only answers a held request, and only lets go once req is gone
  ack_rise_on_req: assert property (@(posedge clk) disable iff (reset)
    $rose(i_ack) |-> $past(i_req))
    else begin
      $error("ack rose without a request");
      error_count++;
    end
  ack_fall_on_release: assert property (@(posedge clk) disable iff (reset)
    $fell(i_ack) |-> !$past(i_req))
    else begin
      $error("ack fell while request still high");
      error_count++;
    end

  // io0 turned around only inside a transaction
  oeb_inside_cs: assert property (@(posedge clk) disable iff (reset)
    i_tex_oeb0 |-> !i_tex_csb)
    else begin
      $error("io0 is an input while chip select is high");
      error_count++;
    end
  out0_quiet_idle: assert property (@(posedge clk) disable iff (reset)
    i_tex_csb |-> !i_tex_out0)
    else begin
      $error("io0 toggles while chip select is high");
      error_count++;
    end

endmodule

bind raycast_top raycast_assertions i_assertions (
  .clk        (clk),
  .reset      (reset),
  .i_req      (i_req),
  .i_ack      (o_ack),
  .i_tex_csb  (o_tex_csb),
  .i_tex_oeb0 (o_tex_oeb0),
  .i_tex_out0 (o_tex_out0)
);

//--- tb/raycast_tb.sv
module raycast_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import raycast_pkg::*;

  localparam logic [31:0] SEED = 32'h5d8e_9105;
  localparam int NUM_LINES   = 8;   // Rendered lines under test
  localparam int ACK_TIMEOUT = 16;  // Cycles allowed per handshake edge
  localparam int CS_END  = FETCH_START + TSPI_PREAMBLE_LEN + TSPI_READ_LEN;  // First hpos after CS
  localparam int OEB_BEG = FETCH_START + TSPI_CMD_LEN + TSPI_ADDR_LEN;

  logic       clk;
  logic       reset;
  logic       i_req;
  wall_id_t   i_wall_id;
  logic       i_side;
  texel_idx_t i_texu;
  wall_size_t i_wall_size;
  tex_step_t  i_tex_step;
  rgb_t       i_sky_rgb;
  rgb_t       i_floor_rgb;
  logic [3:0] i_tex_in = 4'h0;  // Flash io driven by the model below
  logic       o_ack;
  logic       o_hsync_n;
  logic       o_vsync_n;
  logic       o_hblank;
  logic       o_vblank;
  pos_t       o_hpos;
  pos_t       o_vpos;
  rgb_t       o_rgb;
  logic       o_tex_csb;
  logic       o_tex_sclk;
  logic       o_tex_out0;
  logic       o_tex_oeb0;

  int          spi_cnt = 0;  // Flash model sclk edges since CS fell
  logic [31:0] spi_shift;
  logic [7:0]  flash_cmd;
  tex_addr_t   flash_addr;
  logic        chk_en;       // Expected display fields of the checked line
  pos_t        chk_vpos;
  wall_size_t  chk_size;
  tex_step_t   chk_step;
  rgb_t        chk_sky;
  rgb_t        chk_floor;
  tex_addr_t   chk_addr;
  int          chk_count;
  int          test_idx;
  logic [31:0] rng_state;

  raycast_top i_dut (
    .clk (clk), .reset (reset), .i_req (i_req), .i_wall_id (i_wall_id), .i_side (i_side),
    .i_texu (i_texu), .i_wall_size (i_wall_size), .i_tex_step (i_tex_step),
    .i_sky_rgb (i_sky_rgb), .i_floor_rgb (i_floor_rgb), .i_tex_in (i_tex_in),
    .o_ack (o_ack), .o_hsync_n (o_hsync_n), .o_vsync_n (o_vsync_n), .o_hblank (o_hblank),
    .o_vblank (o_vblank), .o_hpos (o_hpos), .o_vpos (o_vpos), .o_rgb (o_rgb),
    .o_tex_csb (o_tex_csb), .o_tex_sclk (o_tex_sclk), .o_tex_out0 (o_tex_out0),
    .o_tex_oeb0 (o_tex_oeb0)
  );

  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Flash contents as a hash of the byte address plus nibble number
  function automatic logic [3:0] flash_nibble(input tex_addr_t addr, input int k);
    logic [31:0] h;
    h = xorshift32(xorshift32(SEED ^ (32'(addr) + 32'(k))));
    return h[3:0];
  endfunction

  function automatic tex_addr_t ref_addr(input wall_id_t id, input logic side,
                                         input texel_idx_t u);
    tex_addr_t a;
    a = '0;
    a[14:13] = id;
    a[12]    = side;
    a[11:6]  = u;  // Slice start at 64 bytes per slice
    return a;
  endfunction

  // Texel j from nibbles 2j (colour LSBs) and 2j+1 (colour MSBs)
  function automatic rgb_t ref_texel(input tex_addr_t addr, input int j);
    logic [3:0] lo;
    logic [3:0] hi;
    lo = flash_nibble(addr, 2 * j);
    hi = flash_nibble(addr, 2 * j + 1);
    return {hi[2], lo[2], hi[1], lo[1], hi[0], lo[0]};
  endfunction

  function automatic rgb_t ref_pixel(input int h, input int v, input int size, input int step,
                                     input rgb_t sky, input rgb_t floor, input tex_addr_t addr);
    int lo;
    int hi;
    int tv;
    if (h >= H_VIEW || v >= V_VIEW) return '0;  // Blanking is black
    lo = (size > HALF_VIEW) ? 0 : HALF_VIEW - size;
    hi = HALF_VIEW + size;
    if (h >= lo && h < hi) begin
      tv = ((h - lo) * step) % 4096;  // Wall pixels before this one in a 12-bit accumulator
      return ref_texel(addr, (tv >> TEXV_FRAC_BITS) % TEXEL_COUNT);
    end
    return (h < HALF_VIEW) ? floor : sky;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failed");
    $fatal(1, "wait timed out");
  endtask

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (o_ack !== level) begin
      n++;
      if (n > ACK_TIMEOUT) fail_timeout(what);
      @(negedge clk);
    end
  endtask

  task automatic wait_line_start(input int max_vpos);
    int n;
    n = 0;
    while (!(o_hpos == '0 && int'(o_vpos) <= max_vpos)) begin
      n++;
      if (n > H_TOTAL * V_TOTAL) fail_timeout("a usable line start");
      @(negedge clk);
    end
  endtask

  task automatic wait_line_end(input string what);
    int n;
    n = 0;
    while (int'(o_hpos) != H_TOTAL - 1) begin
      n++;
      if (n > H_TOTAL) fail_timeout(what);
      @(negedge clk);
    end
  endtask

  // Four-phase handshake with req held two cycles past ack
  task automatic send_descriptor(input wall_id_t id, input logic side, input texel_idx_t u,
                                 input wall_size_t size, input tex_step_t step,
                                 input rgb_t sky, input rgb_t floor);
    check_value("ack idle before req", 0, o_ack);
    i_wall_id   = id;
    i_side      = side;
    i_texu      = u;
    i_wall_size = size;
    i_tex_step  = step;
    i_sky_rgb   = sky;
    i_floor_rgb = floor;
    i_req       = 1'b1;
    wait_ack(1'b1, "ack to rise");
    repeat (2) @(negedge clk);
    check_value("ack held with req", 1, o_ack);
    i_req = 1'b0;
    wait_ack(1'b0, "ack to fall");
  endtask

  // Walks the fetch line up to hpos 799 checking CS, io0 direction and serial bits per cycle
  task automatic check_fetch_line(input tex_addr_t addr);
    logic [31:0] frame;
    logic        exp_out0;
    logic        done;
    int          h;
    int          n;
    frame = {TSPI_CMD, addr};
    n     = 0;
    done  = 1'b0;
    while (!done) begin
      h = int'(o_hpos);
      exp_out0 = (h >= FETCH_START && h < OEB_BEG) ? frame[31 - (h - FETCH_START)] : 1'b0;
      check_value($sformatf("csb at hpos %0d", h), !(h >= FETCH_START && h < CS_END), o_tex_csb);
      check_value($sformatf("oeb0 at hpos %0d", h), h >= OEB_BEG && h < CS_END, o_tex_oeb0);
      check_value($sformatf("out0 at hpos %0d", h), exp_out0, o_tex_out0);
      done = (h == H_TOTAL - 1);
      if (!done) begin
        n++;
        if (n > H_TOTAL) fail_timeout("the end of the fetch line");
        @(negedge clk);
      end
    end
    check_value("flash command", TSPI_CMD, flash_cmd);  // As decoded by the flash model
    check_value("flash address", addr, flash_addr);
  endtask

  // Flash clock is clk inverted, compared just after every clk edge
  always @(clk) begin
    #1;
    check_value("tex_sclk", !clk, o_tex_sclk);
  end

  // Flash model samples io0 on rising sclk and drives read data for the next clk rise
  always @(negedge clk) begin
    if (o_tex_csb) begin
      spi_cnt = 0;
      i_tex_in <= 4'h0;
    end else begin
      if (spi_cnt < TSPI_CMD_LEN + TSPI_ADDR_LEN) spi_shift = {spi_shift[30:0], o_tex_out0};
      if (spi_cnt == TSPI_CMD_LEN + TSPI_ADDR_LEN - 1) begin
        flash_cmd  = spi_shift[31:24];
        flash_addr = spi_shift[23:0];
      end
      if (spi_cnt >= TSPI_PREAMBLE_LEN && spi_cnt < TSPI_PREAMBLE_LEN + TSPI_READ_LEN) begin
        i_tex_in <= flash_nibble(flash_addr, spi_cnt - TSPI_PREAMBLE_LEN);
      end else begin
        i_tex_in <= 4'h0;
      end
      spi_cnt++;
    end
  end

  // Pixel checker for the line after a fetch
  always @(negedge clk) begin
    if (chk_en && o_vpos == chk_vpos) begin
      check_value($sformatf("line test %0d rgb at hpos %0d", test_idx, o_hpos),
                  ref_pixel(int'(o_hpos), int'(o_vpos), int'(chk_size), int'(chk_step),
                            chk_sky, chk_floor, chk_addr), o_rgb);
      chk_count++;
    end
  end

  initial begin
    int         exp_h;
    int         exp_v;
    wall_id_t   d_id;
    logic       d_side;
    texel_idx_t d_texu;
    wall_size_t d_size;
    tex_step_t  d_step;
    rgb_t       d_sky;
    rgb_t       d_floor;
    clk         = 1'b0;
    reset       = 1'b1;
    i_req       = 1'b0;
    i_wall_id   = '0;
    i_side      = 1'b0;
    i_texu      = '0;
    i_wall_size = '0;
    i_tex_step  = '0;
    i_sky_rgb   = '0;
    i_floor_rgb = '0;
    chk_en      = 1'b0;
    chk_count   = 0;
    test_idx    = 0;
    rng_state   = SEED;
    repeat (10) @(negedge clk);
    check_value("reset ack", 0, o_ack);
    check_value("reset csb", 1, o_tex_csb);
    check_value("reset oeb0", 0, o_tex_oeb0);
    check_value("reset hpos", 0, o_hpos);
    check_value("reset vpos", 0, o_vpos);
    reset = 1'b0;

    // One full frame of sync and blanking
    exp_h = 0;
    exp_v = 0;
    for (int i = 0; i < H_TOTAL * V_TOTAL; i++) begin
      check_value("frame hpos", exp_h, o_hpos);
      check_value("frame vpos", exp_v, o_vpos);
      check_value("hsync_n", !(exp_h >= H_SYNC_START && exp_h < H_SYNC_END), o_hsync_n);
      check_value("vsync_n", !(exp_v >= V_SYNC_START && exp_v < V_SYNC_END), o_vsync_n);
      check_value("hblank", exp_h >= H_VIEW, o_hblank);
      check_value("vblank", exp_v >= V_VIEW, o_vblank);
      exp_h++;
      if (exp_h == H_TOTAL) begin
        exp_h = 0;
        exp_v = (exp_v + 1) % V_TOTAL;
      end
      @(negedge clk);
    end

    for (int t = 0; t < NUM_LINES; t++) begin
      rng_state = xorshift32(rng_state);
      d_size    = rng_state[8:0];
      d_step    = rng_state[20:9];
      d_id      = rng_state[22:21];
      d_side    = rng_state[23];
      d_texu    = rng_state[29:24];
      rng_state = xorshift32(rng_state);
      d_sky     = rng_state[5:0];
      d_floor   = rng_state[11:6];
      if (t == 0) d_size = '0;                    // No wall at all
      if (t == 1) d_size = wall_size_t'(HALF_VIEW);  // Wall spans the whole view
      if (t == 2) d_step = 12'h0a5;               // Over 2.5 texels per pixel
      test_idx = t;
      wait_line_start(V_VIEW - 2);  // Rendered line must still be visible
      send_descriptor(d_id, d_side, d_texu, d_size, d_step, d_sky, d_floor);
      chk_addr = ref_addr(d_id, d_side, d_texu);
      check_fetch_line(chk_addr);
      chk_size  = d_size;
      chk_step  = d_step;
      chk_sky   = d_sky;
      chk_floor = d_floor;
      chk_vpos  = o_vpos + 1'b1;
      chk_count = 0;
      chk_en    = 1'b1;
      @(negedge clk);
      wait_line_end("the end of the rendered line");
      @(negedge clk);
      chk_en = 1'b0;
      check_value("pixels checked on rendered line", H_TOTAL, chk_count);
    end

    if (i_dut.i_assertions.error_count != 0) begin
      $display("Bound assertions reported %0d failures", i_dut.i_assertions.error_count);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- all.f
hw/raycast_pkg.sv
hw/vga_timing.sv
hw/texture_fetch_ctrl.sv
hw/qspi_serializer.sv
hw/texel_buffer.sv
hw/wall_column_render.sv
hw/raycast_top.sv
tb/raycast_assertions.sv
tb/raycast_tb.sv
